// File: common/noc_pkg.sv
//////////////////////////////////////////////////
// NoC shared definitions
// Port directions, head flit layout, FSM states
//////////////////////////////////////////////////

`default_nettype none

package noc_pkg;

  //////////////////////////////////////////////////
  // Router ports
  //////////////////////////////////////////////////

  // Port index inside a router
  // North is row + 1, east is column + 1
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    SOUTH = 3'd3,
    WEST  = 3'd4
  } port_dir_t;

  // Local plus four neighbors
  localparam int PORT_COUNT = 5;

  //////////////////////////////////////////////////
  // Head flit layout
  //////////////////////////////////////////////////

  // Width of one destination coordinate
  localparam int COORD_W = 4;

  // Destination column in the low nibble
  localparam int DEST_X_LSB = 0;

  // Destination row in the next nibble
  localparam int DEST_Y_LSB = 4;

  //////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////

  // Input port
  // IDLE_HEAD means the next accepted flit opens a packet
  typedef enum logic {
    IDLE_HEAD = 1'b0,
    IN_PACKET = 1'b1
  } in_state_t;

  // Output arbiter
  // LOCKED holds the grant until the last flit leaves
  typedef enum logic {
    FREE   = 1'b0,
    LOCKED = 1'b1
  } arb_state_t;

endpackage

`default_nettype wire

// File: common/noc_link_if.sv
//////////////////////////////////////////////////
// NoC link
// One flit channel with valid/ready handshake
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface noc_link_if #(
  parameter int FLIT_W = 32
);

  // Payload of the current flit
  logic [FLIT_W-1:0] flit;
  // High on the final flit of a packet
  logic              last;
  // Flit on the link is valid
  logic              valid;
  // Receiver takes the flit on this edge
  logic              ready;

  // Upstream side
  // Holds flit and last while valid and not ready
  modport sender (
    output flit,
    output last,
    output valid,
    input  ready
  );

  // Downstream side
  modport receiver (
    input  flit,
    input  last,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

// File: router/noc_input_port.sv
//////////////////////////////////////////////////
// Router input port
// One-flit buffer plus XY route for the head flit
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_input_port #(
  parameter int X_DIM  = 2,
  parameter int Y_DIM  = 2,
  parameter int FLIT_W = 32,
  parameter int MY_X   = 0,
  parameter int MY_Y   = 0
) (
  input  wire                            clk,
  input  wire                            rst,
  noc_link_if.receiver                   link_in,
  output logic [noc_pkg::PORT_COUNT-1:0] req,
  output logic [FLIT_W-1:0]              flit,
  output logic                           last,
  input  wire                            grant_ready
);

  noc_pkg::in_state_t state;
  noc_pkg::port_dir_t dir_q;
  logic               full;
  logic               drain;
  logic               accept;

  // Dimension-order route, column first then row
  // Never points off the grid edge, stray addresses end up local
  function automatic noc_pkg::port_dir_t route(input logic [FLIT_W-1:0] head);
    int dest_x;
    int dest_y;
    dest_x = int'(head[noc_pkg::DEST_X_LSB +: noc_pkg::COORD_W]);
    dest_y = int'(head[noc_pkg::DEST_Y_LSB +: noc_pkg::COORD_W]);
    if (dest_x > MY_X && MY_X < X_DIM - 1) begin
      return noc_pkg::EAST;
    end else if (dest_x < MY_X) begin
      return noc_pkg::WEST;
    end else if (dest_y > MY_Y && MY_Y < Y_DIM - 1) begin
      return noc_pkg::NORTH;
    end else if (dest_y < MY_Y) begin
      return noc_pkg::SOUTH;
    end
    return noc_pkg::LOCAL;
  endfunction

  // Buffered flit leaves through its granted output
  assign drain  = full && grant_ready;
  // Free slot, or the slot empties on this edge
  assign link_in.ready = !full || drain;
  assign accept = link_in.valid && link_in.ready;

  // One-hot request toward the output of the held route
  assign req = full ? ({{(noc_pkg::PORT_COUNT-1){1'b0}}, 1'b1} << dir_q) : '0;

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      full  <= 1'b0;
      state <= noc_pkg::IDLE_HEAD;
      dir_q <= noc_pkg::LOCAL;
    end else begin
      if (accept) begin
        full <= 1'b1;
      end else if (drain) begin
        full <= 1'b0;
      end
      if (accept) begin
        // New route only on a head flit, body flits follow it
        if (state == noc_pkg::IDLE_HEAD) begin
          dir_q <= route(link_in.flit);
        end
        state <= link_in.last ? noc_pkg::IDLE_HEAD : noc_pkg::IN_PACKET;
      end
    end
  end

  // Flit storage
  always_ff @(posedge clk) begin
    if (accept) begin
      flit <= link_in.flit;
      last <= link_in.last;
    end
  end

endmodule

`default_nettype wire

// File: router/noc_output_arbiter.sv
//////////////////////////////////////////////////
// Router output arbiter
// Round-robin grant held for a whole packet
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_output_arbiter (
  input  wire                            clk,
  input  wire                            rst,
  input  wire  [noc_pkg::PORT_COUNT-1:0] req,
  input  wire                            last_fire,
  output logic [noc_pkg::PORT_COUNT-1:0] grant
);

  noc_pkg::arb_state_t             state;
  // Winner of the previous arbitration
  noc_pkg::port_dir_t              last_winner;
  noc_pkg::port_dir_t              pick_idx;
  logic [noc_pkg::PORT_COUNT-1:0]  pick;
  logic [noc_pkg::PORT_COUNT-1:0]  grant_q;

  //////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////

  // Search starts just after the previous winner
  always_comb begin
    int idx;
    pick     = '0;
    pick_idx = last_winner;
    for (int i = 1; i <= noc_pkg::PORT_COUNT; i++) begin
      idx = (int'(last_winner) + i) % noc_pkg::PORT_COUNT;
      if (req[idx] && pick == '0) begin
        pick[idx] = 1'b1;
        pick_idx  = noc_pkg::port_dir_t'(idx);
      end
    end
  end

  // Same-cycle grant when free, held grant while locked
  assign grant = (state == noc_pkg::LOCKED) ? grant_q : pick;

  //////////////////////////////////////////////////
  // Lock FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= noc_pkg::FREE;
      grant_q     <= '0;
      // First search starts at the local port
      last_winner <= noc_pkg::WEST;
    end else begin
      case (state)
        noc_pkg::FREE: begin
          if (pick != '0) begin
            last_winner <= pick_idx;
            grant_q     <= pick;
            // Single-flit packet leaves at once, no lock needed
            if (!last_fire) begin
              state <= noc_pkg::LOCKED;
            end
          end
        end
        noc_pkg::LOCKED: begin
          if (last_fire) begin
            state <= noc_pkg::FREE;
          end
        end
        default: state <= noc_pkg::FREE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: router/noc_router.sv
//////////////////////////////////////////////////
// Five-port wormhole router
// Input buffers, output arbiters and crossbar
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter int X_DIM  = 2,
  parameter int Y_DIM  = 2,
  parameter int FLIT_W = 32,
  parameter int MY_X   = 0,
  parameter int MY_Y   = 0
) (
  input wire           clk,
  input wire           rst,
  noc_link_if.receiver in_link  [noc_pkg::PORT_COUNT],
  noc_link_if.sender   out_link [noc_pkg::PORT_COUNT]
);

  localparam int P = noc_pkg::PORT_COUNT;

  // Per input, indexed by output
  logic [P-1:0]      in_req  [P];
  logic [FLIT_W-1:0] in_flit [P];
  logic              in_last [P];
  // Per output, indexed by input
  logic [P-1:0]      sel     [P];
  logic              out_ready [P];

  // Inputs that may feed output dst under XY routing
  // No u-turns except local, no turn from a column into a row
  // Forbidden pairs are left out of the crossbar, so ready paths stay acyclic
  function automatic logic [P-1:0] turn_mask(input int dst);
    logic [P-1:0] m;
    m = '1;
    if (dst != noc_pkg::LOCAL) begin
      m[dst] = 1'b0;
    end
    if (dst == noc_pkg::EAST || dst == noc_pkg::WEST) begin
      m[noc_pkg::NORTH] = 1'b0;
      m[noc_pkg::SOUTH] = 1'b0;
    end
    return m;
  endfunction

  //////////////////////////////////////////////////
  // Input ports
  //////////////////////////////////////////////////
  for (genvar i = 0; i < P; i++) begin : g_in
    logic grant_ready;

    // Ready of whichever output this input holds
    always_comb begin
      grant_ready = 1'b0;
      for (int o = 0; o < P; o++) begin
        grant_ready = grant_ready | (sel[o][i] & out_ready[o]);
      end
    end

    noc_input_port #(
      .X_DIM  (X_DIM),
      .Y_DIM  (Y_DIM),
      .FLIT_W (FLIT_W),
      .MY_X   (MY_X),
      .MY_Y   (MY_Y)
    ) u_in (
      .clk         (clk),
      .rst         (rst),
      .link_in     (in_link[i]),
      .req         (in_req[i]),
      .flit        (in_flit[i]),
      .last        (in_last[i]),
      .grant_ready (grant_ready)
    );
  end

  //////////////////////////////////////////////////
  // Output arbiters and crossbar
  //////////////////////////////////////////////////
  for (genvar o = 0; o < P; o++) begin : g_out
    localparam logic [P-1:0] ALLOWED = turn_mask(o);
    logic [P-1:0]      arb_req;
    logic [P-1:0]      arb_grant;
    logic [FLIT_W-1:0] mux_flit;
    logic              mux_last;
    logic              mux_valid;

    // Gather this output's column of the request matrix
    always_comb begin
      for (int i = 0; i < P; i++) begin
        arb_req[i] = in_req[i][o] & ALLOWED[i];
      end
    end

    noc_output_arbiter u_arb (
      .clk       (clk),
      .rst       (rst),
      .req       (arb_req),
      .last_fire (mux_valid && out_ready[o] && mux_last),
      .grant     (arb_grant)
    );

    assign sel[o] = arb_grant & ALLOWED;

    // AND-OR mux over the one-hot selection
    always_comb begin
      mux_flit = '0;
      mux_last = 1'b0;
      for (int i = 0; i < P; i++) begin
        mux_flit = mux_flit | (in_flit[i] & {FLIT_W{sel[o][i]}});
        mux_last = mux_last | (in_last[i] & sel[o][i]);
      end
    end

    // Valid only while the held input has a flit buffered
    assign mux_valid = |(sel[o] & arb_req);

    assign out_link[o].flit  = mux_flit;
    assign out_link[o].last  = mux_last;
    assign out_link[o].valid = mux_valid;
    assign out_ready[o]      = out_link[o].ready;
  end

endmodule

`default_nettype wire

// File: design/noc_mesh.sv
//////////////////////////////////////////////////
// 2D mesh NoC top level
// Router grid, neighbor links and edge tie-offs
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_mesh #(
  parameter int X_DIM  = 2,
  parameter int Y_DIM  = 2,
  parameter int FLIT_W = 32
) (
  input  wire                                 clk,
  input  wire                                 rst,

  // Local injection, node n = column + row * X_DIM
  input  wire  [X_DIM*Y_DIM-1:0][FLIT_W-1:0]  in_flit,
  input  wire  [X_DIM*Y_DIM-1:0]              in_last,
  input  wire  [X_DIM*Y_DIM-1:0]              in_valid,
  output logic [X_DIM*Y_DIM-1:0]              in_ready,

  // Local ejection
  output logic [X_DIM*Y_DIM-1:0][FLIT_W-1:0]  out_flit,
  output logic [X_DIM*Y_DIM-1:0]              out_last,
  output logic [X_DIM*Y_DIM-1:0]              out_valid,
  input  wire  [X_DIM*Y_DIM-1:0]              out_ready
);

  localparam int NODES = X_DIM * Y_DIM;
  localparam int P     = noc_pkg::PORT_COUNT;

  // Link signals per node and port, seen from the router
  logic [FLIT_W-1:0] node_in_flit   [NODES][P];
  logic              node_in_last   [NODES][P];
  logic              node_in_valid  [NODES][P];
  logic              node_in_ready  [NODES][P];
  logic [FLIT_W-1:0] node_out_flit  [NODES][P];
  logic              node_out_last  [NODES][P];
  logic              node_out_valid [NODES][P];
  logic              node_out_ready [NODES][P];

  // Node number of the neighbor behind port p
  function automatic int neighbor(input int x, input int y, input int p);
    int nx;
    int ny;
    nx = x;
    ny = y;
    case (p)
      noc_pkg::NORTH: ny = y + 1;
      noc_pkg::SOUTH: ny = y - 1;
      noc_pkg::EAST:  nx = x + 1;
      noc_pkg::WEST:  nx = x - 1;
      default: ;
    endcase
    return nx + ny * X_DIM;
  endfunction

  // Port on the neighbor that faces back
  function automatic int opposite(input int p);
    case (p)
      noc_pkg::NORTH: return noc_pkg::SOUTH;
      noc_pkg::SOUTH: return noc_pkg::NORTH;
      noc_pkg::EAST:  return noc_pkg::WEST;
      noc_pkg::WEST:  return noc_pkg::EAST;
      default:        return noc_pkg::LOCAL;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Router grid
  //////////////////////////////////////////////////
  for (genvar y = 0; y < Y_DIM; y++) begin : g_row
    for (genvar x = 0; x < X_DIM; x++) begin : g_col
      localparam int N = x + y * X_DIM;

      noc_link_if #(.FLIT_W(FLIT_W)) in_if  [P] ();
      noc_link_if #(.FLIT_W(FLIT_W)) out_if [P] ();

      noc_router #(
        .X_DIM  (X_DIM),
        .Y_DIM  (Y_DIM),
        .FLIT_W (FLIT_W),
        .MY_X   (x),
        .MY_Y   (y)
      ) u_router (
        .clk      (clk),
        .rst      (rst),
        .in_link  (in_if),
        .out_link (out_if)
      );

      for (genvar p = 0; p < P; p++) begin : g_port
        localparam bit HAS_NB = (p == noc_pkg::NORTH && y < Y_DIM - 1) ||
                                (p == noc_pkg::SOUTH && y > 0) ||
                                (p == noc_pkg::EAST  && x < X_DIM - 1) ||
                                (p == noc_pkg::WEST  && x > 0);

        // Router side of the link
        assign in_if[p].flit         = node_in_flit[N][p];
        assign in_if[p].last         = node_in_last[N][p];
        assign in_if[p].valid        = node_in_valid[N][p];
        assign node_in_ready[N][p]   = in_if[p].ready;
        assign node_out_flit[N][p]   = out_if[p].flit;
        assign node_out_last[N][p]   = out_if[p].last;
        assign node_out_valid[N][p]  = out_if[p].valid;
        assign out_if[p].ready       = node_out_ready[N][p];

        if (p == noc_pkg::LOCAL) begin : g_local
          // Local port goes to the top-level node ports
          assign node_in_flit[N][p]   = in_flit[N];
          assign node_in_last[N][p]   = in_last[N];
          assign node_in_valid[N][p]  = in_valid[N];
          assign in_ready[N]          = node_in_ready[N][p];
          assign out_flit[N]          = node_out_flit[N][p];
          assign out_last[N]          = node_out_last[N][p];
          assign out_valid[N]         = node_out_valid[N][p];
          assign node_out_ready[N][p] = out_ready[N];
        end else if (HAS_NB) begin : g_link
          // Neighbor output feeds this input, and back
          assign node_in_flit[N][p]   = node_out_flit[neighbor(x, y, p)][opposite(p)];
          assign node_in_last[N][p]   = node_out_last[neighbor(x, y, p)][opposite(p)];
          assign node_in_valid[N][p]  = node_out_valid[neighbor(x, y, p)][opposite(p)];
          assign node_out_ready[N][p] = node_in_ready[neighbor(x, y, p)][opposite(p)];
        end else begin : g_edge
          // Grid edge, nothing arrives and nothing leaves
          assign node_in_flit[N][p]   = '0;
          assign node_in_last[N][p]   = 1'b0;
          assign node_in_valid[N][p]  = 1'b0;
          assign node_out_ready[N][p] = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/noc_clock_gen.sv
//////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock, reset held for a few cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge, in step with the stimulus
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: sim/noc_mesh_tb.sv
//////////////////////////////////////////////////
// Mesh NoC testbench
// Per-source injection, scoreboard and checks
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module noc_mesh_tb;

  localparam int          X_DIM         = 2;
  localparam int          Y_DIM         = 2;
  localparam int          FLIT_W        = 32;
  localparam int          NODES         = X_DIM * Y_DIM;
  localparam logic [31:0] SEED          = 32'hcca3_397f;
  localparam int          RESET_TIMEOUT = 100;
  localparam int          DRAIN_TIMEOUT = 4000;

  logic                          clk;
  logic                          rst;
  logic [NODES-1:0][FLIT_W-1:0]  in_flit;
  logic [NODES-1:0]              in_last;
  logic [NODES-1:0]              in_valid;
  logic [NODES-1:0]              in_ready;
  logic [NODES-1:0][FLIT_W-1:0]  out_flit;
  logic [NODES-1:0]              out_last;
  logic [NODES-1:0]              out_valid;
  logic [NODES-1:0]              out_ready;

  int   errors;
  int   checks;
  int   tests;
  int   start_errors;
  int   target;
  logic bp_on;
  // Set once any wait runs out
  logic timed_out;

  // Entries are {last, flit}
  logic [FLIT_W:0] send_q [NODES][$];
  // Expected flits indexed by dest * NODES + src
  logic [FLIT_W:0] exp_q  [NODES*NODES][$];
  // Source of the packet in progress per output or -1 between packets
  int              cur_src [NODES];
  int              seq_cnt [NODES];
  // Output stalled on the previous edge and what it showed
  logic            hold_v  [NODES];
  logic [FLIT_W:0] hold_f  [NODES];

  noc_clock_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (8)
  ) u_clk (
    .clk (clk),
    .rst (rst)
  );

  noc_mesh #(
    .X_DIM  (X_DIM),
    .Y_DIM  (Y_DIM),
    .FLIT_W (FLIT_W)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (in_flit),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  //////////////////////////////////////////////////
  // Packet building and scoreboard
  //////////////////////////////////////////////////

  // Source, sequence and flit index above the destination byte
  function automatic logic [FLIT_W-1:0] make_flit(input int src, input int seq,
                                                  input int idx, input int dest);
    logic [FLIT_W-1:0] f;
    f        = '0;
    f[31:24] = 8'(src);
    f[23:16] = 8'(seq);
    f[15:8]  = 8'(idx);
    f[3:0]   = 4'(dest % X_DIM);
    f[7:4]   = 4'(dest / X_DIM);
    return f;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NODES * NODES; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  task automatic send_packet(input int src, input int dest, input int len);
    logic [FLIT_W:0] e;
    for (int i = 0; i < len; i++) begin
      e = {(i == len - 1), make_flit(src, seq_cnt[src], i, dest)};
      send_q[src].push_back(e);
      exp_q[dest * NODES + src].push_back(e);
    end
    seq_cnt[src]++;
  endtask

  // Body flits belong to the packet in progress and a head names its source
  task automatic check_flit(input int d, input logic [FLIT_W-1:0] f, input logic l);
    int              s;
    logic            known;
    logic [FLIT_W:0] e;
    s     = (cur_src[d] >= 0) ? cur_src[d] : int'(f[31:24]);
    known = (s < NODES) ? (exp_q[d * NODES + s].size() > 0) : 1'b0;
    checks++;
    assert (f[7:0] == make_flit(0, 0, 0, d)) else begin
      $display("error: out_flit[%0d] dest field got %h expected %h", d, f[7:0],
               make_flit(0, 0, 0, d) & 32'hff);
      errors++;
    end
    checks++;
    assert (known) else begin
      $display("node %0d received a flit that no source sent to it: %h", d, f);
      errors++;
    end
    if (known) begin
      e = exp_q[d * NODES + s].pop_front();
      checks++;
      assert ({l, f} == e) else begin
        $display("error: out_flit[%0d] {last,flit} got %h expected %h", d, {l, f}, e);
        errors++;
      end
      cur_src[d] = l ? -1 : s;
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers and monitor
  //////////////////////////////////////////////////

  // Front of each send queue stays on the link until taken
  always @(negedge clk) begin
    for (int s = 0; s < NODES; s++) begin
      if (send_q[s].size() > 0) begin
        in_flit[s]  = send_q[s][0][FLIT_W-1:0];
        in_last[s]  = send_q[s][0][FLIT_W];
        in_valid[s] = 1'b1;
      end else begin
        in_flit[s]  = '0;
        in_last[s]  = 1'b0;
        in_valid[s] = 1'b0;
      end
      out_ready[s] = bp_on ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      for (int d = 0; d < NODES; d++) begin
        // A stalled output holds its flit
        if (hold_v[d]) begin
          checks++;
          assert (out_valid[d] && {out_last[d], out_flit[d]} == hold_f[d]) else begin
            $display("error: out_flit[%0d] changed while stalled, got %h expected %h", d,
                     {out_last[d], out_flit[d]}, hold_f[d]);
            errors++;
          end
        end
        hold_v[d] = out_valid[d] && !out_ready[d];
        hold_f[d] = {out_last[d], out_flit[d]};
        if (out_valid[d] && out_ready[d]) begin
          check_flit(d, out_flit[d], out_last[d]);
        end
        if (in_valid[d] && in_ready[d]) begin
          void'(send_q[d].pop_front());
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Sequencing helpers
  //////////////////////////////////////////////////

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < RESET_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("timeout: reset still asserted after %0d cycles", n);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // Until every expected flit has arrived
  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (!timed_out && outstanding() != 0 && n < DRAIN_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!timed_out && outstanding() != 0) begin
      $display("timeout: %s still has %0d flits undelivered after %0d cycles", name,
               outstanding(), n);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name, input int first_errors);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - first_errors);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    in_flit   = '0;
    in_last   = '0;
    in_valid  = '0;
    out_ready = '1;
    bp_on     = 1'b0;
    timed_out = 1'b0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    for (int d = 0; d < NODES; d++) begin
      cur_src[d] = -1;
      seq_cnt[d] = 0;
      hold_v[d]  = 1'b0;
      hold_f[d]  = '0;
    end
    wait_reset_release();

    // Reset state
    start_errors = errors;
    @(negedge clk);
    checks++;
    assert (out_valid == '0) else begin
      $display("error: out_valid got %h expected %h", out_valid, {NODES{1'b0}});
      errors++;
    end
    checks++;
    assert (in_ready == '1) else begin
      $display("error: in_ready got %h expected %h", in_ready, {NODES{1'b1}});
      errors++;
    end
    end_test("reset state", start_errors);

    // Every source to every node, itself included
    start_errors = errors;
    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        send_packet(s, d, 1);
      end
    end
    wait_drain("all pairs");
    end_test("all pairs", start_errors);

    // Two to four flits per packet
    start_errors = errors;
    for (int k = 0; k < 3; k++) begin
      for (int s = 0; s < NODES; s++) begin
        send_packet(s, $urandom_range(0, NODES - 1), $urandom_range(2, 4));
      end
    end
    wait_drain("multi-flit");
    end_test("multi-flit packets", start_errors);

    // Random stalls on every local output
    start_errors = errors;
    bp_on = 1'b1;
    for (int k = 0; k < 4; k++) begin
      for (int s = 0; s < NODES; s++) begin
        send_packet(s, $urandom_range(0, NODES - 1), $urandom_range(1, 4));
      end
    end
    wait_drain("back-pressure");
    bp_on = 1'b0;
    end_test("back-pressure", start_errors);

    // All sources into one node
    start_errors = errors;
    target = $urandom_range(0, NODES - 1);
    for (int k = 0; k < 4; k++) begin
      for (int s = 0; s < NODES; s++) begin
        send_packet(s, target, $urandom_range(1, 4));
      end
    end
    wait_drain("contention");
    end_test("contention", start_errors);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
common/noc_pkg.sv
common/noc_link_if.sv
router/noc_input_port.sv
router/noc_output_arbiter.sv
router/noc_router.sv
design/noc_mesh.sv
sim/noc_clock_gen.sv
sim/noc_mesh_tb.sv

// File: Makefile
# Verilator build and run for the mesh NoC testbench

VERILATOR ?= verilator
TOP       ?= noc_mesh_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Output is echoed, then searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
